//--- list.f
+incdir+.
predecodePkg.sv
creditQueue.sv
instrAligner.sv
lanePredecoder.sv
bundleCollector.sv
predecodeTop.sv
predecodeTb.sv

//--- Bender.yml
package:
  name: predecode

sources:
  - include_dirs:
      - .
    files:
      - predecodePkg.sv
      - creditQueue.sv
      - instrAligner.sv
      - lanePredecoder.sv
      - bundleCollector.sv
      - predecodeTop.sv
  - target: test
    include_dirs:
      - .
    files:
      - predecodeTb.sv

//--- predecodeTbChecks.svh
// ----------------------------------------------------------------------
// reference model
// ----------------------------------------------------------------------

// builds one expected instruction from the ordering and prediction rules.
task automatic expectInstr(
    input logic [31:0] instr,
    input logic [31:0] pc,
    input logic        compressed,
    input FetchBlock   blk,
    input int          lastPos
);
    PredecodedInstr p;
    p            = '0;
    p.valid      = 1'b1;
    p.pc         = pc;
    p.instr      = instr;
    p.compressed = compressed;
    p.fetchId    = blk.fetchId;
    p.predTaken  = blk.predTaken && blk.predPos == lastPos;
    p.ctrl       = classOf.exists(pc) ? classOf[pc] : CtrlNone;
    p.target     = targetOf.exists(pc) ? targetOf[pc] : '0;
    p.badPred    = p.predTaken && p.ctrl == CtrlNone;
    expQ.push_back(p);
endtask

// walks the valid halfwords of a block in program order.
task automatic expectBlock(input FetchBlock blk);
    logic [15:0] hw;
    logic [31:0] pc;
    for (int i = 0; i < `FETCH_WIDTH; i++) begin
        hw = blk.halfwords[i];
        pc = blk.pc + i * 2;
        if (blk.validMask[i] && pendValid) begin
            expectInstr({hw, pendLow}, pendPc, 1'b0, blk, i);
            pendValid = 1'b0;
        end else if (blk.validMask[i] && hw[1:0] != 2'b11) begin
            expectInstr({16'h0000, hw}, pc, 1'b1, blk, i);
        end else if (blk.validMask[i]) begin
            // low half of a full-width instruction waits for its upper half.
            pendValid = 1'b1;
            pendLow   = hw;
            pendPc    = pc;
        end
    end
endtask

// ----------------------------------------------------------------------
// compare tasks
// ----------------------------------------------------------------------

task automatic checkInstr(input PredecodedInstr got, input PredecodedInstr exp);
    logic direct;
    direct = exp.ctrl == CtrlBranch || exp.ctrl == CtrlJal;
    checked++;
    if (got.pc !== exp.pc || got.instr !== exp.instr || got.compressed !== exp.compressed
            || got.fetchId !== exp.fetchId || got.predTaken !== exp.predTaken
            || got.ctrl !== exp.ctrl || got.badPred !== exp.badPred
            || (direct && got.target !== exp.target)) begin
        errors++;
        $display("Mismatch at %0t: got pc %h instr %h c %b fid %0d taken %b %s tgt %h bad %b",
                 $time, got.pc, got.instr, got.compressed, got.fetchId, got.predTaken,
                 got.ctrl.name(), got.target, got.badPred);
        $display("    expected pc %h instr %h c %b fid %0d taken %b %s tgt %h bad %b",
                 exp.pc, exp.instr, exp.compressed, exp.fetchId, exp.predTaken,
                 exp.ctrl.name(), exp.target, exp.badPred);
    end
endtask

task automatic checkCredits(input string what, input int got, input int exp);
    if (got != exp) begin
        errors++;
        $display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
endtask

//--- predecodeTb.sv
`timescale 1ns/100ps
`include "predecode_defines.svh"

module predecodeTb
    import predecodePkg::*;
();

    localparam int TimeoutCycles = 200;

    typedef struct {
        int    test;
        string pattern;
        logic  predTaken;
        int    predPos;
        logic  flushFirst;
        int    withhold;
    } StimRow;

    logic           clk;
    logic           rst;
    logic           flush;
    logic           fetchValid;
    FetchBlock      fetchBlock;
    logic           fetchCredit;
    logic           outValid;
    PredecodeBundle outBundle;
    logic           outCredit;

    StimRow         rows[$];
    PredecodedInstr expQ[$];
    CtrlClass       classOf [logic [31:0]];
    logic [31:0]    targetOf [logic [31:0]];
    int             seed;
    int             errors;
    int             checked;
    int             credits;
    int             pulses;
    int             blocks;
    int             owed;
    int             withholdLeft;
    logic           pendValid;
    logic [15:0]    pendLow;
    logic [31:0]    pendPc;

    `include "predecodeTbChecks.svh"

    predecodeTop u_predecodeTop (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .fetchValid  (fetchValid),
        .fetchBlock  (fetchBlock),
        .fetchCredit (fetchCredit),
        .outValid    (outValid),
        .outBundle   (outBundle),
        .outCredit   (outCredit)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ----------------------------------------------------------------------
    // stimulus generation
    // ----------------------------------------------------------------------

    task automatic addRow(input int test, input string pattern, input logic predTaken,
                          input int predPos, input logic flushFirst, input int withhold);
        StimRow row;
        row.test       = test;
        row.pattern    = pattern;
        row.predTaken  = predTaken;
        row.predPos    = predPos;
        row.flushFirst = flushFirst;
        row.withhold   = withhold;
        rows.push_back(row);
    endtask

    // random even offset that fits a signed field of the given width.
    function automatic logic [31:0] randOff(input int bits);
        logic [31:0] r;
        r    = $random(seed);
        r    = r << (32 - bits);
        r    = $signed(r) >>> (32 - bits);
        r[0] = 1'b0;
        return r;
    endfunction

    function automatic void noteCtrl(input logic [31:0] pc, input CtrlClass cls,
                                     input logic [31:0] off);
        classOf[pc]  = cls;
        targetOf[pc] = pc + off;
    endfunction

    // pattern letters: c plain compressed, l plain full-width low half, h upper half,
    // - invalid, j c.j, b c.beqz, n c.bnez, r c.jr, J jal, B branch, R jalr.
    function automatic FetchBlock makeBlock(input StimRow row, input int idx);
        FetchBlock   blk;
        logic [31:0] word;
        logic [31:0] off;
        logic [31:0] pc;
        logic        wide;
        int          i;
        blk           = '0;
        blk.pc        = 32'h0001_0000 + idx * 16;
        blk.fetchId   = idx[`FETCH_ID_W-1:0];
        blk.predTaken = row.predTaken;
        blk.predPos   = row.predPos[`HW_IDX_W-1:0];
        i = 0;
        while (i < `FETCH_WIDTH) begin
            word = $random(seed);
            pc   = blk.pc + i * 2;
            wide = 1'b0;
            blk.validMask[i] = row.pattern[i] != "-";
            case (row.pattern[i])
                "c": word[15:0] = {3'b000, word[12:2], 2'b01};
                "l": word[6:0] = 7'b0010011;
                "j": begin
                    off = randOff(12);
                    word[15:0] = {3'b101, off[11], off[4], off[9:8], off[10], off[6], off[7],
                                  off[3:1], off[5], 2'b01};
                    noteCtrl(pc, CtrlJal, off);
                end
                "b", "n": begin
                    off = randOff(9);
                    word[15:0] = {(row.pattern[i] == "b") ? 3'b110 : 3'b111, off[8], off[4:3],
                                  3'b010, off[7:6], off[2:1], off[5], 2'b01};
                    noteCtrl(pc, CtrlBranch, off);
                end
                "r": begin
                    word[15:0]  = {4'b1000, 5'd1, 5'd0, 2'b10};
                    classOf[pc] = CtrlJalr;
                end
                "J": begin
                    off  = randOff(21);
                    word = {off[20], off[10:1], off[11], off[19:12], 5'd1, 7'b1101111};
                    wide = 1'b1;
                    noteCtrl(pc, CtrlJal, off);
                end
                "B": begin
                    off  = randOff(13);
                    word = {off[12], off[10:5], 5'd3, 5'd2, 3'b001, off[4:1], off[11],
                            7'b1100011};
                    wide = 1'b1;
                    noteCtrl(pc, CtrlBranch, off);
                end
                "R": begin
                    word[19:0]  = {5'd1, 3'b000, 5'd0, 7'b1100111};
                    wide        = 1'b1;
                    classOf[pc] = CtrlJalr;
                end
                default: begin
                end
            endcase
            blk.halfwords[i] = word[15:0];
            if (wide) begin
                blk.halfwords[i + 1] = word[31:16];
                blk.validMask[i + 1] = 1'b1;
                i = i + 2;
            end else begin
                i = i + 1;
            end
        end
        return blk;
    endfunction

    task automatic buildTable();
        addRow(1, "lhlhlhlh", 1'b0, 0, 1'b0, 0);
        addRow(1, "lhlhlhlh", 1'b0, 0, 1'b0, 0);
        addRow(2, "cclhclhc", 1'b0, 0, 1'b0, 6);
        addRow(2, "lhcclhcc", 1'b0, 0, 1'b0, 0);
        addRow(3, "cclhcccl", 1'b0, 0, 1'b0, 0);
        addRow(3, "hclhcccc", 1'b1, 0, 1'b0, 0);
        addRow(4, "--clh-c-", 1'b1, 4, 1'b0, 0);
        addRow(4, "c-cc-jc-", 1'b1, 5, 1'b0, 0);
        addRow(5, "jbBhJhrn", 1'b0, 0, 1'b0, 0);
        addRow(5, "RhcjlhBh", 1'b1, 3, 1'b0, 0);
        // enough bundles to use up the downstream credits while they are withheld.
        addRow(6, "lhcclhcc", 1'b0, 0, 1'b0, 30);
        addRow(6, "cclhclhc", 1'b0, 0, 1'b0, 0);
        addRow(6, "lhlhcccc", 1'b0, 0, 1'b0, 0);
        addRow(7, "lhcclhcc", 1'b0, 0, 1'b0, 0);
        addRow(7, "cclhlhcc", 1'b0, 0, 1'b1, 0);
    endtask

    // ----------------------------------------------------------------------
    // driving and waiting
    // ----------------------------------------------------------------------

    task automatic pushBlock(input FetchBlock blk);
        int waited;
        waited = 0;
        @(posedge clk);
        while (credits == 0 && waited < TimeoutCycles) begin
            fetchValid <= 1'b0;
            @(posedge clk);
            waited++;
        end
        if (credits == 0) begin
            errors++;
            $display("no fetch credit came back within %0d cycles", TimeoutCycles);
        end else begin
            fetchValid <= 1'b1;
            fetchBlock <= blk;
            credits--;
            blocks++;
            expectBlock(blk);
        end
    endtask

    task automatic applyFlush();
        @(posedge clk);
        fetchValid <= 1'b0;
        flush      <= 1'b1;
        pendValid = 1'b0;
        blocks    = 0;
        @(posedge clk);
        flush <= 1'b0;
    endtask

    task automatic waitDrained();
        int waited;
        waited = 0;
        while ((expQ.size() != 0 || credits != `BLOCK_DEPTH) && waited < TimeoutCycles) begin
            @(posedge clk);
            waited++;
        end
        if (expQ.size() != 0) begin
            errors++;
            $display("%0d expected instructions never came out", expQ.size());
        end
    endtask

    // the consumer side hands a credit back one cycle after each bundle.
    always @(posedge clk) begin : monitor
        logic gap;
        if (rst) begin
            outCredit <= 1'b0;
        end else begin
            if (flush) begin
                expQ.delete();
                credits = `BLOCK_DEPTH;
                pulses  = 0;
            end else if (fetchCredit) begin
                credits++;
                pulses++;
            end
            if (outValid) begin
                owed++;
                gap = 1'b0;
                for (int k = 0; k < `DECODE_WIDTH; k++) begin
                    if (!outBundle[k].valid) begin
                        gap = 1'b1;
                    end else if (gap) begin
                        errors++;
                        $display("lane %0d holds an instruction after an empty lane", k);
                    end else if (expQ.size() == 0) begin
                        errors++;
                        $display("instruction at pc %h came out but none was expected",
                                 outBundle[k].pc);
                    end else begin
                        checkInstr(outBundle[k], expQ.pop_front());
                    end
                end
            end
            if (withholdLeft > 0) begin
                withholdLeft--;
                outCredit <= 1'b0;
            end else if (owed > 0) begin
                owed--;
                outCredit <= 1'b1;
            end else begin
                outCredit <= 1'b0;
            end
        end
    end

    initial begin : stimulus
        int errorsBefore;
        int checkedBefore;
        rst          = 1'b1;
        flush        = 1'b0;
        fetchValid   = 1'b0;
        fetchBlock   = '0;
        outCredit    = 1'b0;
        seed         = 32'h793c_a200;
        errors       = 0;
        checked      = 0;
        credits      = `BLOCK_DEPTH;
        pulses       = 0;
        blocks       = 0;
        owed         = 0;
        withholdLeft = 0;
        pendValid    = 1'b0;
        buildTable();
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        errorsBefore  = 0;
        checkedBefore = 0;
        for (int i = 0; i < rows.size(); i++) begin
            if (rows[i].flushFirst) begin
                applyFlush();
            end
            if (rows[i].withhold > 0) begin
                withholdLeft = rows[i].withhold;
            end
            pushBlock(makeBlock(rows[i], i));
            if (i == rows.size() - 1 || rows[i + 1].test != rows[i].test) begin
                @(posedge clk);
                fetchValid <= 1'b0;
                waitDrained();
                checkCredits("fetch credits", credits, `BLOCK_DEPTH);
                checkCredits("fetch credit pulses", pulses, blocks);
                $display("test %0d finished: %0d instructions, %0d errors", rows[i].test,
                         checked - checkedBefore, errors - errorsBefore);
                errorsBefore  = errors;
                checkedBefore = checked;
            end
        end
        $display("%0d instructions checked, %0d errors", checked, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- predecodeTop.sv
`timescale 1ns/100ps
`include "predecode_defines.svh"

module predecodeTop
    import predecodePkg::*;
(
    input  logic           clk,
    input  logic           rst,
    input  logic           flush,
    input  logic           fetchValid,
    input  FetchBlock      fetchBlock,
    output logic           fetchCredit,
    output logic           outValid,
    output PredecodeBundle outBundle,
    input  logic           outCredit
);

    FetchBlock                           headBlock;
    logic                                headValid;
    logic                                pop;
    logic                                advance;
    AlignedInstr [`DECODE_WIDTH-1:0]    alignedLanes;
    PredecodedInstr [`DECODE_WIDTH-1:0] predecodedLanes;

    creditQueue #(
        .Payload (FetchBlock),
        .Depth   (`BLOCK_DEPTH)
    ) u_blockQueue (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .push      (fetchValid),
        .pushData  (fetchBlock),
        .pop       (pop),
        .headData  (headBlock),
        .headValid (headValid),
        .credit    (fetchCredit)
    );

    instrAligner u_aligner (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .advance   (advance),
        .head      (headBlock),
        .headValid (headValid),
        .pop       (pop),
        .lanes     (alignedLanes)
    );

    for (genvar k = 0; k < `DECODE_WIDTH; k++) begin : g_lane
        lanePredecoder u_lane (
            .clk      (clk),
            .rst      (rst),
            .flush    (flush),
            .advance  (advance),
            .inInstr  (alignedLanes[k]),
            .outInstr (predecodedLanes[k])
        );
    end

    bundleCollector u_collector (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .lanesIn   (predecodedLanes),
        .outCredit (outCredit),
        .advance   (advance),
        .outValid  (outValid),
        .outBundle (outBundle)
    );

endmodule

//--- bundleCollector.sv
`timescale 1ns/100ps
`include "predecode_defines.svh"

module bundleCollector
    import predecodePkg::*;
(
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                flush,
    input  PredecodedInstr [`DECODE_WIDTH-1:0] lanesIn,
    input  logic                                outCredit,
    output logic                                advance,
    output logic                                outValid,
    output PredecodeBundle                      outBundle
);

    localparam int CntW = $clog2(`OUT_CREDITS + 1);

    logic [CntW-1:0] creditCount;
    logic            bundleValid;
    logic            anyLaneValid;

    always_comb begin
        anyLaneValid = 1'b0;
        for (int k = 0; k < `DECODE_WIDTH; k++) begin
            anyLaneValid = anyLaneValid | lanesIn[k].valid;
        end
    end

    // the whole pipe moves only while the consumer has room.
    assign advance  = creditCount != '0;
    assign outValid = advance && bundleValid && !flush;

    // ------------------------------------------------------------------
    // downstream credits
    // ------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            creditCount <= CntW'(`OUT_CREDITS);
        end else begin
            creditCount <= creditCount - CntW'(outValid) + CntW'(outCredit);
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            bundleValid <= 1'b0;
        end else if (advance) begin
            bundleValid <= anyLaneValid;
            outBundle   <= lanesIn;
        end
    end

    // the consumer never hands back more than it was given.
    creditBound: assert property (@(posedge clk) disable iff (rst)
        creditCount <= CntW'(`OUT_CREDITS));

endmodule

//--- lanePredecoder.sv
`timescale 1ns/100ps
`include "predecode_defines.svh"

module lanePredecoder
    import predecodePkg::*;
(
    input  logic           clk,
    input  logic           rst,
    input  logic           flush,
    input  logic           advance,
    input  AlignedInstr    inInstr,
    output PredecodedInstr outInstr
);

    logic [31:0]      w;
    logic [`PC_W-1:0] cjImm;
    logic [`PC_W-1:0] cbImm;
    logic [`PC_W-1:0] jImm;
    logic [`PC_W-1:0] bImm;
    logic [`PC_W-1:0] imm;
    CtrlClass         ctrl;
    PredecodedInstr   nextOut;

    assign w = inInstr.instr;

    // scattered immediate fields of the compressed and full jump formats.
    assign cjImm = {{21{w[12]}}, w[8], w[10:9], w[6], w[7], w[2], w[11], w[5:3], 1'b0};
    assign cbImm = {{24{w[12]}}, w[6:5], w[2], w[11:10], w[4:3], 1'b0};
    assign jImm  = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    assign bImm  = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};

    always_comb begin
        ctrl = CtrlNone;
        imm  = '0;
        if (inInstr.compressed) begin
            case ({w[15:13], w[1:0]})
                5'b101_01, 5'b001_01: begin
                    ctrl = CtrlJal;
                    imm  = cjImm;
                end
                5'b110_01, 5'b111_01: begin
                    ctrl = CtrlBranch;
                    imm  = cbImm;
                end
                // c.jr and c.jalr need a nonzero rs1 and a zero rs2.
                5'b100_10: begin
                    if (w[11:7] != 5'd0 && w[6:2] == 5'd0) begin
                        ctrl = CtrlJalr;
                    end
                end
                default: begin
                end
            endcase
        end else begin
            case (w[6:0])
                7'b1101111: begin
                    ctrl = CtrlJal;
                    imm  = jImm;
                end
                7'b1100011: begin
                    ctrl = CtrlBranch;
                    imm  = bImm;
                end
                7'b1100111: ctrl = CtrlJalr;
                default: begin
                end
            endcase
        end
    end

    always_comb begin
        nextOut.valid      = inInstr.valid;
        nextOut.pc         = inInstr.pc;
        nextOut.instr      = inInstr.instr;
        nextOut.compressed = inInstr.compressed;
        nextOut.fetchId    = inInstr.fetchId;
        nextOut.predTaken  = inInstr.predTaken;
        nextOut.ctrl       = ctrl;
        nextOut.target     = (ctrl == CtrlBranch || ctrl == CtrlJal) ? inInstr.pc + imm : '0;
        // a taken prediction on a plain instruction cannot be right.
        nextOut.badPred    = inInstr.predTaken && ctrl == CtrlNone;
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            outInstr.valid <= 1'b0;
        end else if (advance) begin
            outInstr <= nextOut;
        end
    end

endmodule

//--- instrAligner.sv
`timescale 1ns/100ps
`include "predecode_defines.svh"

module instrAligner
    import predecodePkg::*;
(
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             flush,
    input  logic                             advance,
    input  FetchBlock                        head,
    input  logic                             headValid,
    output logic                             pop,
    output AlignedInstr [`DECODE_WIDTH-1:0] lanes
);

    localparam int IdxW = `HW_IDX_W;
    localparam logic [IdxW:0] NoPos = (IdxW + 1)'(`FETCH_WIDTH);

    // ------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------

    // first valid halfword at or after from, or NoPos when none is left.
    function automatic logic [IdxW:0] nextValid(
        input logic [`FETCH_WIDTH-1:0] mask,
        input logic [IdxW:0]           from
    );
        logic [IdxW:0] pos;
        pos = NoPos;
        for (int j = `FETCH_WIDTH - 1; j >= 0; j--) begin
            if (mask[j] && j >= from) begin
                pos = (IdxW + 1)'(j);
            end
        end
        return pos;
    endfunction

    function automatic logic [`PC_W-1:0] hwPc(
        input FetchBlock     blk,
        input logic [IdxW:0] pos
    );
        return {blk.pc[`PC_W-1:IdxW+1], pos[IdxW-1:0], 1'b0};
    endfunction

    // fetch id and prediction follow the block that holds the last halfword.
    function automatic AlignedInstr makeLane(
        input FetchBlock        blk,
        input logic [`PC_W-1:0] pc,
        input logic [31:0]      instr,
        input logic [IdxW:0]    lastPos
    );
        AlignedInstr lane;
        lane.valid      = 1'b1;
        lane.pc         = pc;
        lane.instr      = instr;
        lane.compressed = instr[1:0] != 2'b11;
        lane.fetchId    = blk.fetchId;
        lane.predTaken  = blk.predTaken && blk.predPos == lastPos[IdxW-1:0];
        return lane;
    endfunction

    // ------------------------------------------------------------------
    // halfword walk
    // ------------------------------------------------------------------

    logic [IdxW-1:0]                  idx;
    logic                             pendValid;
    logic [15:0]                      pendLow;
    logic [`PC_W-1:0]                 pendPc;

    AlignedInstr [`DECODE_WIDTH-1:0] laneNext;
    logic [IdxW:0]                    curNext;
    logic                             pendValidNext;
    logic [15:0]                      pendLowNext;
    logic [`PC_W-1:0]                 pendPcNext;
    logic                             exhausted;

    always_comb begin : walk
        logic [IdxW:0] cur;
        logic [IdxW:0] pos;
        logic [IdxW:0] pos2;
        logic [15:0]   hw;
        logic          stop;

        cur           = {1'b0, idx};
        stop          = !headValid;
        pendValidNext = pendValid;
        pendLowNext   = pendLow;
        pendPcNext    = pendPc;
        laneNext      = '0;
        for (int k = 0; k < `DECODE_WIDTH; k++) begin
            pos  = nextValid(head.validMask, cur);
            pos2 = NoPos;
            hw   = head.halfwords[pos[IdxW-1:0]];
            if (pos == NoPos) begin
                stop = 1'b1;
            end
            if (!stop) begin
                if (pendValidNext) begin
                    // upper half of an instruction begun in the previous block.
                    laneNext[k]   = makeLane(head, pendPcNext, {hw, pendLowNext}, pos);
                    pendValidNext = 1'b0;
                    cur           = pos + 1'b1;
                end else if (hw[1:0] != 2'b11) begin
                    laneNext[k] = makeLane(head, hwPc(head, pos), {16'h0000, hw}, pos);
                    cur         = pos + 1'b1;
                end else begin
                    pos2 = nextValid(head.validMask, pos + 1'b1);
                    if (pos2 == NoPos) begin
                        // the upper half lives in the next block, which is not visible yet.
                        pendValidNext = 1'b1;
                        pendLowNext   = hw;
                        pendPcNext    = hwPc(head, pos);
                        cur           = pos + 1'b1;
                        stop          = 1'b1;
                    end else begin
                        laneNext[k] = makeLane(head, hwPc(head, pos),
                                               {head.halfwords[pos2[IdxW-1:0]], hw}, pos2);
                        cur         = pos2 + 1'b1;
                    end
                end
            end
        end
        curNext   = cur;
        exhausted = nextValid(head.validMask, cur) == NoPos;
    end

    assign pop = advance && headValid && exhausted;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            idx       <= '0;
            pendValid <= 1'b0;
            for (int k = 0; k < `DECODE_WIDTH; k++) begin
                lanes[k].valid <= 1'b0;
            end
        end else if (advance) begin
            lanes <= laneNext;
            if (headValid) begin
                idx       <= exhausted ? '0 : curNext[IdxW-1:0];
                pendValid <= pendValidNext;
                pendLow   <= pendLowNext;
                pendPc    <= pendPcNext;
            end
        end
    end

    // the block is popped exactly when its last valid halfword is used.
    idxInMask: assert property (@(posedge clk) disable iff (rst)
        headValid |-> (head.validMask >> idx) != '0);

endmodule

//--- creditQueue.sv
`timescale 1ns/100ps

module creditQueue #(
    parameter type Payload = logic,
    parameter int  Depth   = 8
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   flush,
    input  logic   push,
    input  Payload pushData,
    input  logic   pop,
    output Payload headData,
    output logic   headValid,
    output logic   credit
);

    localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int CntW = $clog2(Depth + 1);

    Payload          mem [Depth];
    logic [PtrW-1:0] wrPtr;
    logic [PtrW-1:0] rdPtr;
    logic [CntW-1:0] count;

    function automatic logic [PtrW-1:0] bump(input logic [PtrW-1:0] ptr);
        return (ptr == PtrW'(Depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= pushData;
        end
    end

    // a push in a flush cycle is dropped together with the old contents.
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= bump(wrPtr);
            end
            if (pop) begin
                rdPtr <= bump(rdPtr);
            end
            count <= count + CntW'(push) - CntW'(pop);
        end
    end

    // one credit goes back for every entry that leaves normally.
    always_ff @(posedge clk) begin
        if (rst) begin
            credit <= 1'b0;
        end else begin
            credit <= pop && !flush;
        end
    end

    assign headData  = mem[rdPtr];
    assign headValid = count != '0;

    noPushWhenFull: assert property (@(posedge clk) disable iff (rst || flush)
        push |-> count != CntW'(Depth));

    noPopWhenEmpty: assert property (@(posedge clk) disable iff (rst || flush)
        pop |-> count != '0);

endmodule

//--- predecodePkg.sv
`include "predecode_defines.svh"

package predecodePkg;

    // ------------------------------------------------------------------
    // control transfer classes
    // ------------------------------------------------------------------

    typedef enum logic [1:0] {
        CtrlNone   = 2'd0,
        CtrlBranch = 2'd1,
        CtrlJal    = 2'd2,
        CtrlJalr   = 2'd3
    } CtrlClass;

    // ------------------------------------------------------------------
    // payloads
    // ------------------------------------------------------------------

    // the block PC is aligned to the block size, so its low bits are zero.
    typedef struct packed {
        logic [`PC_W-1:0]              pc;
        logic [`FETCH_WIDTH-1:0][15:0] halfwords;
        logic [`FETCH_WIDTH-1:0]       validMask;
        logic [`FETCH_ID_W-1:0]        fetchId;
        logic                          predTaken;
        logic [`HW_IDX_W-1:0]          predPos;
    } FetchBlock;

    // compressed instructions keep the upper half of instr at zero.
    typedef struct packed {
        logic                   valid;
        logic [`PC_W-1:0]       pc;
        logic [31:0]            instr;
        logic                   compressed;
        logic [`FETCH_ID_W-1:0] fetchId;
        logic                   predTaken;
    } AlignedInstr;

    typedef struct packed {
        logic                   valid;
        logic [`PC_W-1:0]       pc;
        logic [31:0]            instr;
        logic                   compressed;
        logic [`FETCH_ID_W-1:0] fetchId;
        logic                   predTaken;
        CtrlClass               ctrl;
        logic [`PC_W-1:0]       target;
        logic                   badPred;
    } PredecodedInstr;

    // lane 0 holds the oldest instruction.
    typedef PredecodedInstr [`DECODE_WIDTH-1:0] PredecodeBundle;

endpackage

//--- predecode_defines.svh
`ifndef PREDECODE_DEFINES_SVH
`define PREDECODE_DEFINES_SVH

// halfwords carried by one fetch block.
`define FETCH_WIDTH 8

// instructions handed on per cycle.
`define DECODE_WIDTH 4

// block queue entries, which is also the fetch credit count.
`define BLOCK_DEPTH 8

// downstream bundle credits after reset.
`define OUT_CREDITS 4

`define FETCH_ID_W 5

// halfword index within a block.
`define HW_IDX_W $clog2(`FETCH_WIDTH)

`define PC_W 32

`endif
